// ==== sim.f ====
common/tcp_pkg.sv
common/byte_credit_if.sv
design/tcp_checksum_acc.sv
design/tcp_payload_buffer.sv
tcp_gen/tcp_payload_ingest.sv
tcp_gen/tcp_packet_generator.sv
design/tcp_tx_top.sv
sim/tcp_tx_chk.sv
sim/tcp_tx_tb.sv

// ==== sim/tcp_tx_tb.sv ====
`timescale 1ns/1ps

module tcp_tx_tb;

    localparam int max_pay = 64;
    localparam int max_segs = 20;
    localparam int total_segs = 20 + 10 + 16 + 20 + 20;
    localparam int total_bytes = total_segs * (max_pay + 20);
    localparam int cycle_limit = total_bytes * 4 + 200;  // Room for random stalls

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_pay_tdata;
    logic        i_pay_tvalid;
    logic        i_pay_tlast;
    logic        o_pay_tready;
    logic        i_hdr_valid;
    logic        i_no_data;
    logic [31:0] i_src_ip;
    logic [31:0] i_dst_ip;
    logic [15:0] i_src_port;
    logic [15:0] i_dst_port;
    logic [31:0] i_seq_number;
    logic [31:0] i_ack_number;
    logic [7:0]  i_flags;
    logic [15:0] i_window_size;
    logic        o_hdr_ready;
    logic        o_ip_hdr_valid;
    logic [15:0] o_ip_length;
    logic [31:0] o_ip_src;
    logic [31:0] o_ip_dst;
    logic        i_ip_hdr_ready;
    logic [7:0]  o_seg_tdata;
    logic        o_seg_tvalid;
    logic        o_seg_tlast;
    logic        i_seg_tready;
    logic        o_packet_done;

    integer seed = 32'he2ae41cc;
    int     cycles;
    int     errors;
    int     done_count;
    int     tests_run;
    int     tests_failed;
    int     out_seg;
    int     out_byte;
    logic   bp_on;
    string  cur_test;

    // Stimulus of the running test, one entry per segment
    logic        seg_no_data [max_segs];
    int          seg_len [max_segs];
    logic [31:0] h_src_ip [max_segs];
    logic [31:0] h_dst_ip [max_segs];
    logic [15:0] h_src_port [max_segs];
    logic [15:0] h_dst_port [max_segs];
    logic [31:0] h_seq [max_segs];
    logic [31:0] h_ack [max_segs];
    logic [7:0]  h_flags [max_segs];
    logic [15:0] h_window [max_segs];
    logic [7:0]  pay_bytes [$];

    logic [8:0]  exp_bytes [$];  // {last, data}
    logic [79:0] exp_ip [$];     // {length, src, dst}

    tcp_tx_top #(
        .BUF_DEPTH_L2 (6),
        .GEN_CREDITS  (4)
    ) dut (.*);

    bind tcp_tx_top tcp_tx_chk #(
        .BUF_CREDITS (BUF_CREDITS),
        .GEN_CREDITS (GEN_CREDITS)
    ) u_chk (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_buf_valid         (buf_link.valid),
        .i_buf_credit_return (buf_link.credit_return),
        .i_gen_valid         (gen_link.valid),
        .i_gen_credit_return (gen_link.credit_return),
        .i_seg_tdata         (o_seg_tdata),
        .i_seg_tvalid        (o_seg_tvalid),
        .i_seg_tlast         (o_seg_tlast),
        .i_seg_tready        (i_seg_tready),
        .i_packet_done       (o_packet_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic int total_errors();
        return errors + dut.u_chk.fails;
    endfunction

    task automatic report_mismatch(string what, logic [79:0] exp, logic [79:0] act);
        errors++;
        $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, act);
    endtask

    // Reference model, pseudo-header plus header plus zero padded payload
    task automatic expect_segment(int k, logic [7:0] p[$]);
        logic [31:0]  sum;
        logic [15:0]  tcp_len;
        logic [15:0]  csum;
        logic [159:0] hdr;
        int           i;
        tcp_len = 16'(20 + p.size());
        sum = 32'(h_src_ip[k][31:16]) + 32'(h_src_ip[k][15:0])
            + 32'(h_dst_ip[k][31:16]) + 32'(h_dst_ip[k][15:0])
            + 32'h0006 + 32'(tcp_len) + 32'(h_src_port[k]) + 32'(h_dst_port[k])
            + 32'(h_seq[k][31:16]) + 32'(h_seq[k][15:0])
            + 32'(h_ack[k][31:16]) + 32'(h_ack[k][15:0])
            + 32'({8'h50, h_flags[k]}) + 32'(h_window[k]);
        for (i = 0; i < p.size(); i += 2) begin
            sum += (i + 1 < p.size()) ? 32'({p[i], p[i + 1]}) : 32'({p[i], 8'h00});
        end
        sum = 32'(sum[31:16]) + 32'(sum[15:0]);
        sum = 32'(sum[31:16]) + 32'(sum[15:0]);
        csum = ~sum[15:0];
        hdr = {h_src_port[k], h_dst_port[k], h_seq[k], h_ack[k],
               8'h50, h_flags[k], h_window[k], csum, 16'h0000};
        for (i = 0; i < 20; i++) begin
            exp_bytes.push_back({(p.size() == 0) && (i == 19), hdr[159 - 8 * i -: 8]});
        end
        for (i = 0; i < p.size(); i++) begin
            exp_bytes.push_back({i == p.size() - 1, p[i]});
        end
        exp_ip.push_back({16'(40 + p.size()), h_src_ip[k], h_dst_ip[k]});
    endtask

    task automatic make_segments(int n, int nodata_pct, bit odd_only);
        logic [7:0] p[$];
        int         k;
        int         i;
        for (k = 0; k < n; k++) begin
            p.delete();
            seg_no_data[k] = ({$random(seed)} % 100) < nodata_pct;
            h_src_ip[k] = $random(seed);
            h_dst_ip[k] = $random(seed);
            h_src_port[k] = 16'($random(seed));
            h_dst_port[k] = 16'($random(seed));
            h_seq[k] = $random(seed);
            h_ack[k] = $random(seed);
            h_flags[k] = 8'($random(seed));
            h_window[k] = 16'($random(seed));
            if (seg_no_data[k]) begin
                seg_len[k] = 0;
            end else if (odd_only) begin
                seg_len[k] = 2 * int'({$random(seed)} % 32) + 1;
            end else begin
                seg_len[k] = 1 + int'({$random(seed)} % max_pay);
            end
            for (i = 0; i < seg_len[k]; i++) begin
                p.push_back(8'($random(seed)));
                pay_bytes.push_back(p[i]);
            end
            expect_segment(k, p);
        end
    endtask

    task automatic wait_done(int k);
        while (done_count < k) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic drive_payloads(int n, bit overlap);
        int k;
        int i;
        @(posedge i_clk);
        #1;
        for (k = 0; k < n; k++) begin
            if (!seg_no_data[k]) begin
                if (!overlap) wait_done(k);
                i = 0;
                while (i < seg_len[k]) begin
                    i_pay_tvalid = 1'b1;
                    i_pay_tdata = pay_bytes[0];
                    i_pay_tlast = (i == seg_len[k] - 1);
                    @(negedge i_clk);
                    if (o_pay_tready) begin
                        void'(pay_bytes.pop_front());
                        i++;
                    end
                    @(posedge i_clk);
                    #1;
                end
                i_pay_tvalid = 1'b0;
                i_pay_tlast = 1'b0;
            end
        end
    endtask

    task automatic drive_headers(int n, bit overlap);
        int   k;
        logic taken;
        @(posedge i_clk);
        #1;
        for (k = 0; k < n; k++) begin
            if (!overlap) wait_done(k);
            i_no_data = seg_no_data[k];
            i_src_ip = h_src_ip[k];
            i_dst_ip = h_dst_ip[k];
            i_src_port = h_src_port[k];
            i_dst_port = h_dst_port[k];
            i_seq_number = h_seq[k];
            i_ack_number = h_ack[k];
            i_flags = h_flags[k];
            i_window_size = h_window[k];
            i_hdr_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge i_clk);
                taken = o_hdr_ready;
                @(posedge i_clk);
                #1;
            end
            i_hdr_valid = 1'b0;
        end
    endtask

    task automatic run_test(string name, int n, int nodata_pct, bit odd_only, bit bp,
                            bit overlap);
        int err_start;
        @(negedge i_clk);
        cur_test = name;
        err_start = total_errors();
        out_seg = 0;
        out_byte = 0;
        done_count = 0;
        make_segments(n, nodata_pct, odd_only);
        bp_on = bp;
        fork
            drive_payloads(n, overlap);
            drive_headers(n, overlap);
        join
        while (done_count < n) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        bp_on = 1'b0;
        if (exp_bytes.size() != 0 || exp_ip.size() != 0) begin
            errors++;
            $display("%s: %0d bytes and %0d IP headers never came out", name,
                     exp_bytes.size(), exp_ip.size());
        end
        if (done_count != n) begin
            errors++;
            $display("%s: %0d packet done pulses for %0d segments", name, done_count, n);
        end
        tests_run++;
        if (total_errors() != err_start) tests_failed++;
        $display("Test %s: %0d segments, %0d errors", name, n, total_errors() - err_start);
    endtask

    // Sinks, ready held high unless the test stalls them
    initial begin
        i_seg_tready = 1'b1;
        i_ip_hdr_ready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            if (bp_on) begin
                i_seg_tready = ($random(seed) & 3) != 0;
                i_ip_hdr_ready = ($random(seed) & 1) != 0;
            end else begin
                i_seg_tready = 1'b1;
                i_ip_hdr_ready = 1'b1;
            end
        end
    end

    initial begin : output_monitor
        logic [8:0]  exp_b;
        logic [79:0] exp_h;
        wait (i_rst === 1'b0);
        forever begin
            @(negedge i_clk);
            if (o_ip_hdr_valid && i_ip_hdr_ready) begin
                if (exp_ip.size() == 0) begin
                    errors++;
                    $display("%s: IP header offered with no segment outstanding", cur_test);
                end else begin
                    exp_h = exp_ip.pop_front();
                    if ({o_ip_length, o_ip_src, o_ip_dst} != exp_h) begin
                        report_mismatch($sformatf("seg %0d ip header", out_seg), exp_h,
                                        {o_ip_length, o_ip_src, o_ip_dst});
                    end
                end
            end
            if (o_seg_tvalid && i_seg_tready) begin
                if (exp_bytes.size() == 0) begin
                    errors++;
                    $display("%s: extra output byte %02h", cur_test, o_seg_tdata);
                end else begin
                    exp_b = exp_bytes.pop_front();
                    if ({o_seg_tlast, o_seg_tdata} != exp_b) begin
                        report_mismatch($sformatf("seg %0d byte %0d {last,data}", out_seg,
                                        out_byte), 80'(exp_b), 80'({o_seg_tlast, o_seg_tdata}));
                    end
                end
                out_byte++;
                if (o_seg_tlast) begin
                    out_byte = 0;
                    out_seg++;
                end
            end
            if (o_packet_done) begin
                done_count++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        i_pay_tdata = '0;
        i_pay_tvalid = 1'b0;
        i_pay_tlast = 1'b0;
        i_hdr_valid = 1'b0;
        i_no_data = 1'b0;
        i_src_ip = '0;
        i_dst_ip = '0;
        i_src_port = '0;
        i_dst_port = '0;
        i_seq_number = '0;
        i_ack_number = '0;
        i_flags = '0;
        i_window_size = '0;
        bp_on = 1'b0;
        errors = 0;
        done_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "reset_state";
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        @(negedge i_clk);
        if (o_ip_hdr_valid !== 1'b0 || o_hdr_ready !== 1'b0 || o_seg_tvalid !== 1'b0
            || o_packet_done !== 1'b0) begin
            errors++;
            $display("reset_state: a valid, ready or done output is not low after reset");
        end
        tests_run++;
        if (errors != 0) tests_failed++;
        $display("Test reset_state: %0d errors", errors);
        run_test("basic_segments", 20, 0, 1'b0, 1'b0, 1'b0);
        run_test("header_only", 10, 100, 1'b0, 1'b0, 1'b0);
        run_test("odd_lengths", 16, 0, 1'b1, 1'b0, 1'b0);
        run_test("back_pressure", 20, 20, 1'b0, 1'b1, 1'b0);
        run_test("early_payload", 20, 20, 1'b0, 1'b1, 1'b1);
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/tcp_tx_chk.sv ====
`timescale 1ns/1ps

module tcp_tx_chk #(
    parameter int BUF_CREDITS = 2048,
    parameter int GEN_CREDITS = 4
) (
    input logic       i_clk,
    input logic       i_rst,
    input logic       i_buf_valid,
    input logic       i_buf_credit_return,
    input logic       i_gen_valid,
    input logic       i_gen_credit_return,
    input logic [7:0] i_seg_tdata,
    input logic       i_seg_tvalid,
    input logic       i_seg_tlast,
    input logic       i_seg_tready,
    input logic       i_packet_done
);

    int fails = 0;
    int buf_room;   // Free receiver entries as seen on the link
    int gen_room;
    int seg_bytes;  // Bytes of the current segment already taken

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            buf_room <= BUF_CREDITS;
            gen_room <= GEN_CREDITS;
            seg_bytes <= 0;
        end else begin
            buf_room <= buf_room - int'(i_buf_valid) + int'(i_buf_credit_return);
            gen_room <= gen_room - int'(i_gen_valid) + int'(i_gen_credit_return);
            if (i_seg_tvalid && i_seg_tready) begin
                seg_bytes <= i_seg_tlast ? 0 : seg_bytes + 1;
            end
        end
    end

    a_buf_credit: assert property (@(posedge i_clk) disable iff (i_rst)
        i_buf_valid |-> (buf_room > 0))
        else begin
            $error("byte sent toward the payload buffer without a credit");
            fails++;
        end

    a_gen_credit: assert property (@(posedge i_clk) disable iff (i_rst)
        i_gen_valid |-> (gen_room > 0))
        else begin
            $error("byte sent toward the generator without a credit");
            fails++;
        end

    a_seg_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_seg_tvalid && !i_seg_tready) |=> (i_seg_tvalid && $stable(i_seg_tdata)))
        else begin
            $error("segment byte changed or dropped while stalled");
            fails++;
        end

    // Done closes a segment that carried at least the full header
    a_done_last: assert property (@(posedge i_clk) disable iff (i_rst)
        i_packet_done |-> (i_seg_tlast && seg_bytes >= 19))
        else begin
            $error("packet done without the final byte of a whole segment");
            fails++;
        end

endmodule

// ==== design/tcp_tx_top.sv ====
`timescale 1ns/1ps

module tcp_tx_top #(
    parameter int BUF_DEPTH_L2 = 11,
    parameter int GEN_CREDITS  = 4
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [7:0]        i_pay_tdata,
    input  logic              i_pay_tvalid,
    input  logic              i_pay_tlast,
    output logic              o_pay_tready,
    input  logic              i_hdr_valid,
    input  logic              i_no_data,
    input  logic [31:0]       i_src_ip,
    input  logic [31:0]       i_dst_ip,
    input  logic [15:0]       i_src_port,
    input  logic [15:0]       i_dst_port,
    input  logic [31:0]       i_seq_number,
    input  logic [31:0]       i_ack_number,
    input  logic [7:0]        i_flags,
    input  logic [15:0]       i_window_size,
    output logic              o_hdr_ready,
    output logic              o_ip_hdr_valid,
    output tcp_pkg::pay_len_t o_ip_length,
    output logic [31:0]       o_ip_src,
    output logic [31:0]       o_ip_dst,
    input  logic              i_ip_hdr_ready,
    output logic [7:0]        o_seg_tdata,
    output logic              o_seg_tvalid,
    output logic              o_seg_tlast,
    input  logic              i_seg_tready,
    output logic              o_packet_done
);

    import tcp_pkg::*;

    localparam int BUF_CREDITS = 1 << BUF_DEPTH_L2;  // Ingest may fill the whole buffer

    seg_summary_t sum;
    logic         sum_valid;
    logic         sum_ready;

    byte_credit_if buf_link ();
    byte_credit_if gen_link ();

    tcp_payload_ingest #(
        .BUF_CREDITS (BUF_CREDITS)
    ) u_ingest (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pay_tdata  (i_pay_tdata),
        .i_pay_tvalid (i_pay_tvalid),
        .i_pay_tlast  (i_pay_tlast),
        .o_pay_tready (o_pay_tready),
        .o_buf        (buf_link.sender),
        .o_sum        (sum),
        .o_sum_valid  (sum_valid),
        .i_sum_ready  (sum_ready)
    );

    tcp_payload_buffer #(
        .BUF_DEPTH_L2 (BUF_DEPTH_L2),
        .GEN_CREDITS  (GEN_CREDITS)
    ) u_buffer (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_wr  (buf_link.receiver),
        .o_rd  (gen_link.sender)
    );

    tcp_packet_generator #(
        .GEN_CREDITS (GEN_CREDITS)
    ) u_generator (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_hdr_valid    (i_hdr_valid),
        .i_no_data      (i_no_data),
        .i_src_ip       (i_src_ip),
        .i_dst_ip       (i_dst_ip),
        .i_src_port     (i_src_port),
        .i_dst_port     (i_dst_port),
        .i_seq_number   (i_seq_number),
        .i_ack_number   (i_ack_number),
        .i_flags        (i_flags),
        .i_window_size  (i_window_size),
        .o_hdr_ready    (o_hdr_ready),
        .i_sum          (sum),
        .i_sum_valid    (sum_valid),
        .o_sum_ready    (sum_ready),
        .o_ip_hdr_valid (o_ip_hdr_valid),
        .o_ip_length    (o_ip_length),
        .o_ip_src       (o_ip_src),
        .o_ip_dst       (o_ip_dst),
        .i_ip_hdr_ready (i_ip_hdr_ready),
        .i_pay          (gen_link.receiver),
        .o_seg_tdata    (o_seg_tdata),
        .o_seg_tvalid   (o_seg_tvalid),
        .o_seg_tlast    (o_seg_tlast),
        .i_seg_tready   (i_seg_tready),
        .o_packet_done  (o_packet_done)
    );

endmodule

// ==== tcp_gen/tcp_packet_generator.sv ====
`timescale 1ns/1ps

module tcp_packet_generator #(
    parameter int GEN_CREDITS = 4
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_hdr_valid,
    input  logic                  i_no_data,
    input  logic [31:0]           i_src_ip,
    input  logic [31:0]           i_dst_ip,
    input  logic [15:0]           i_src_port,
    input  logic [15:0]           i_dst_port,
    input  logic [31:0]           i_seq_number,
    input  logic [31:0]           i_ack_number,
    input  logic [7:0]            i_flags,
    input  logic [15:0]           i_window_size,
    output logic                  o_hdr_ready,
    input  tcp_pkg::seg_summary_t i_sum,
    input  logic                  i_sum_valid,
    output logic                  o_sum_ready,
    output logic                  o_ip_hdr_valid,
    output tcp_pkg::pay_len_t     o_ip_length,
    output logic [31:0]           o_ip_src,
    output logic [31:0]           o_ip_dst,
    input  logic                  i_ip_hdr_ready,
    byte_credit_if.receiver       i_pay,
    output logic [7:0]            o_seg_tdata,
    output logic                  o_seg_tvalid,
    output logic                  o_seg_tlast,
    input  logic                  i_seg_tready,
    output logic                  o_packet_done
);

    import tcp_pkg::*;

    localparam int skid_aw = $clog2(GEN_CREDITS);  // GEN_CREDITS is a power of two
    localparam int hdr_last = tcp_hdr_bytes - 1;
    localparam logic [3:0] csum_words = 4'd8;

    gen_state_e state;
    logic [3:0] word_cnt;
    logic [4:0] byte_cnt;
    logic       hdr_take;

    logic        no_data_r;
    pay_len_t    pay_len_r;
    csum_t       pay_raw_r;
    logic [31:0] src_ip_r;
    logic [31:0] dst_ip_r;
    logic [31:0] seq_r;
    logic [31:0] ack_r;
    logic [15:0] src_port_r;
    logic [15:0] dst_port_r;
    logic [15:0] window_r;
    logic [7:0]  flags_r;

    logic         acc_clear;
    logic         acc_enable;
    logic [31:0]  acc_word;
    csum_t        tcp_csum;
    pay_len_t     tcp_len;
    logic [159:0] hdr_bits;

    logic [8:0]         skid_mem [GEN_CREDITS];
    logic [skid_aw-1:0] skid_wr_ptr;
    logic [skid_aw-1:0] skid_rd_ptr;
    logic [skid_aw:0]   skid_count;
    logic               skid_pop;

    // A data segment waits here until ingest has its summary
    assign hdr_take = (state == gen_idle) && i_hdr_valid && (i_no_data || i_sum_valid);
    assign o_sum_ready = (state == gen_idle) && i_hdr_valid && !i_no_data;

    assign o_ip_hdr_valid = (state == gen_ip_hdr);
    assign o_hdr_ready = (state == gen_ip_hdr) && i_ip_hdr_ready;
    assign o_ip_length = ip_hdr_bytes + tcp_hdr_bytes + pay_len_r;
    assign o_ip_src = src_ip_r;
    assign o_ip_dst = dst_ip_r;

    always_ff @(posedge i_clk) begin
        if (hdr_take) begin
            no_data_r <= i_no_data;
            pay_len_r <= i_no_data ? '0 : i_sum.len;
            pay_raw_r <= i_no_data ? '0 : ~i_sum.csum;  // Back to the raw folded sum
            src_ip_r <= i_src_ip;
            dst_ip_r <= i_dst_ip;
            src_port_r <= i_src_port;
            dst_port_r <= i_dst_port;
            seq_r <= i_seq_number;
            ack_r <= i_ack_number;
            flags_r <= i_flags;
            window_r <= i_window_size;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= gen_idle;
            word_cnt <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                gen_idle: begin
                    if (hdr_take) begin
                        state <= gen_ip_hdr;
                    end
                end
                gen_ip_hdr: begin
                    word_cnt <= '0;
                    byte_cnt <= '0;
                    if (i_ip_hdr_ready) begin
                        state <= gen_tcp_hdr;
                    end
                end
                gen_tcp_hdr: begin
                    if (word_cnt != csum_words) begin
                        word_cnt <= word_cnt + 1'b1;
                    end else if (i_seg_tready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 5'(hdr_last)) begin
                            state <= no_data_r ? gen_idle : gen_payload;
                        end
                    end
                end
                gen_payload: begin
                    if (o_packet_done) begin
                        state <= gen_idle;
                    end
                end
                default: state <= gen_idle;
            endcase
        end
    end

    // Pseudo-header first, then the header with zero checksum and urgent pointer
    assign tcp_len = tcp_hdr_bytes + pay_len_r;
    assign acc_clear = (state == gen_idle);
    assign acc_enable = (state == gen_tcp_hdr) && (word_cnt != csum_words);

    always_comb begin
        case (word_cnt)
            4'd0: acc_word = src_ip_r;
            4'd1: acc_word = dst_ip_r;
            4'd2: acc_word = {8'h00, tcp_protocol, tcp_len};
            4'd3: acc_word = {src_port_r, dst_port_r};
            4'd4: acc_word = seq_r;
            4'd5: acc_word = ack_r;
            4'd6: acc_word = {tcp_data_offset, 4'h0, flags_r, window_r};
            default: acc_word = {16'h0000, pay_raw_r};
        endcase
    end

    tcp_checksum_acc u_checksum (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_clear    (acc_clear),
        .i_enable   (acc_enable),
        .i_data     (acc_word),
        .o_checksum (tcp_csum)
    );

    assign hdr_bits = {src_port_r, dst_port_r, seq_r, ack_r,
                       tcp_data_offset, 4'h0, flags_r, window_r,
                       tcp_csum, 16'h0000};

    always_comb begin
        o_seg_tvalid = 1'b0;
        o_seg_tlast = 1'b0;
        o_seg_tdata = hdr_bits[8 * (hdr_last - int'(byte_cnt)) +: 8];
        if (state == gen_tcp_hdr && word_cnt == csum_words) begin
            o_seg_tvalid = 1'b1;
            o_seg_tlast = no_data_r && (byte_cnt == 5'(hdr_last));
        end else if (state == gen_payload) begin
            o_seg_tvalid = (skid_count != '0);
            {o_seg_tlast, o_seg_tdata} = skid_mem[skid_rd_ptr];
        end
    end

    assign o_packet_done = o_seg_tvalid && o_seg_tlast && i_seg_tready;
    assign skid_pop = (state == gen_payload) && o_seg_tvalid && i_seg_tready;

    // Skid may fill early with the next segment, credits keep it from overflowing
    always_ff @(posedge i_clk) begin
        if (i_pay.valid) begin
            skid_mem[skid_wr_ptr] <= {i_pay.last, i_pay.data};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            skid_wr_ptr <= '0;
            skid_rd_ptr <= '0;
            skid_count <= '0;
            i_pay.credit_return <= 1'b0;
        end else begin
            if (i_pay.valid) begin
                skid_wr_ptr <= skid_wr_ptr + 1'b1;
            end
            if (skid_pop) begin
                skid_rd_ptr <= skid_rd_ptr + 1'b1;
            end
            skid_count <= skid_count + (skid_aw + 1)'(i_pay.valid)
                                     - (skid_aw + 1)'(skid_pop);
            i_pay.credit_return <= skid_pop;
        end
    end

endmodule

// ==== tcp_gen/tcp_payload_ingest.sv ====
`timescale 1ns/1ps

module tcp_payload_ingest #(
    parameter int BUF_CREDITS = 2048
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [7:0]            i_pay_tdata,
    input  logic                  i_pay_tvalid,
    input  logic                  i_pay_tlast,
    output logic                  o_pay_tready,
    byte_credit_if.sender         o_buf,
    output tcp_pkg::seg_summary_t o_sum,
    output logic                  o_sum_valid,
    input  logic                  i_sum_ready
);

    import tcp_pkg::*;

    localparam int cred_w = $clog2(BUF_CREDITS + 1);

    logic [cred_w-1:0] credits;
    logic              accept;
    logic              odd_byte;  // High byte of a word is waiting
    logic [7:0]        hi_byte;
    logic [15:0]       add_word;
    csum_t             run_sum;
    csum_t             sum_next;
    pay_len_t          len_cnt;

    function automatic csum_t ones_add(csum_t a, csum_t b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + csum_t'(t[16]);
    endfunction

    // Stall while the summary of the last segment is still unclaimed
    assign o_pay_tready = (credits != '0) && !o_sum_valid;
    assign accept = i_pay_tvalid && o_pay_tready;

    // Big-endian words, a lone trailing byte is padded with zero
    assign add_word = odd_byte ? {hi_byte, i_pay_tdata} : {i_pay_tdata, 8'h00};
    assign sum_next = (odd_byte || i_pay_tlast) ? ones_add(run_sum, add_word) : run_sum;

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_buf.data <= i_pay_tdata;
            o_buf.last <= i_pay_tlast;
            if (!odd_byte) begin
                hi_byte <= i_pay_tdata;
            end
            if (i_pay_tlast) begin
                o_sum.len <= len_cnt + 1'b1;
                o_sum.csum <= ~sum_next;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            credits <= cred_w'(BUF_CREDITS);
            odd_byte <= 1'b0;
            run_sum <= '0;
            len_cnt <= '0;
            o_sum_valid <= 1'b0;
            o_buf.valid <= 1'b0;
        end else begin
            credits <= credits - cred_w'(accept) + cred_w'(o_buf.credit_return);
            o_buf.valid <= accept;
            if (o_sum_valid && i_sum_ready) begin
                o_sum_valid <= 1'b0;
            end
            if (accept) begin
                if (i_pay_tlast) begin
                    odd_byte <= 1'b0;
                    run_sum <= '0;
                    len_cnt <= '0;
                    o_sum_valid <= 1'b1;
                end else begin
                    odd_byte <= !odd_byte;
                    run_sum <= sum_next;
                    len_cnt <= len_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/tcp_payload_buffer.sv ====
`timescale 1ns/1ps

module tcp_payload_buffer #(
    parameter int BUF_DEPTH_L2 = 11,
    parameter int GEN_CREDITS  = 4
) (
    input  logic            i_clk,
    input  logic            i_rst,
    byte_credit_if.receiver i_wr,
    byte_credit_if.sender   o_rd
);

    localparam int depth = 1 << BUF_DEPTH_L2;
    localparam int cred_w = $clog2(GEN_CREDITS + 1);

    logic [8:0] mem [depth];  // {last, data}

    logic [BUF_DEPTH_L2-1:0] wr_ptr;
    logic [BUF_DEPTH_L2-1:0] rd_ptr;
    logic [BUF_DEPTH_L2:0]   seg_count;  // Complete segments in store
    logic [cred_w-1:0]       dn_credits;

    logic       rd_en;
    logic       seg_in;
    logic       seg_out;
    logic [8:0] rd_entry;

    assign rd_entry = mem[rd_ptr];

    // Store and forward, nothing leaves before its segment is whole
    assign rd_en = (seg_count != '0) && (dn_credits != '0);
    assign seg_in = i_wr.valid && i_wr.last;
    assign seg_out = rd_en && rd_entry[8];

    always_ff @(posedge i_clk) begin
        if (i_wr.valid) begin
            mem[wr_ptr] <= {i_wr.last, i_wr.data};
        end
        if (rd_en) begin
            {o_rd.last, o_rd.data} <= rd_entry;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            seg_count <= '0;
            dn_credits <= cred_w'(GEN_CREDITS);
            o_rd.valid <= 1'b0;
            i_wr.credit_return <= 1'b0;
        end else begin
            if (i_wr.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            seg_count <= seg_count + (BUF_DEPTH_L2 + 1)'(seg_in)
                                   - (BUF_DEPTH_L2 + 1)'(seg_out);
            dn_credits <= dn_credits - cred_w'(rd_en) + cred_w'(o_rd.credit_return);
            o_rd.valid <= rd_en;
            i_wr.credit_return <= rd_en;  // Entry is free once read
        end
    end

endmodule

// ==== design/tcp_checksum_acc.sv ====
`timescale 1ns/1ps

module tcp_checksum_acc (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_clear,
    input  logic           i_enable,
    input  logic [31:0]    i_data,
    output tcp_pkg::csum_t o_checksum
);

    logic [31:0] sum;
    logic [16:0] fold_a;
    logic [15:0] fold_b;

    // Both halves go in as 16-bit words, carries pile up in the top half
    always_ff @(posedge i_clk) begin
        if (i_rst || i_clear) begin
            sum <= '0;
        end else if (i_enable) begin
            sum <= sum + {16'h0, i_data[31:16]} + {16'h0, i_data[15:0]};
        end
    end

    // Two folds are enough to absorb every end-around carry
    assign fold_a = {1'b0, sum[31:16]} + {1'b0, sum[15:0]};
    assign fold_b = fold_a[15:0] + 16'(fold_a[16]);

    assign o_checksum = ~fold_b;

endmodule

// ==== common/byte_credit_if.sv ====
`timescale 1ns/1ps

// Byte link without ready; the sender may only push while it holds credit
interface byte_credit_if;

    logic       valid;
    logic [7:0] data;
    logic       last;
    logic       credit_return;  // One pulse per freed receiver entry

    modport sender (
        output valid,
        output data,
        output last,
        input  credit_return
    );

    modport receiver (
        input  valid,
        input  data,
        input  last,
        output credit_return
    );

endinterface

// ==== common/tcp_pkg.sv ====
package tcp_pkg;

    localparam int len_width = 16;

    typedef logic [len_width-1:0] pay_len_t;
    typedef logic [15:0] csum_t;

    localparam pay_len_t tcp_hdr_bytes = 16'd20;
    localparam pay_len_t ip_hdr_bytes = 16'd20;

    localparam logic [7:0] tcp_protocol = 8'd6;
    localparam logic [3:0] tcp_data_offset = 4'd5;  // 32-bit words, never any options

    // One finished payload, handed from ingest to the generator
    typedef struct packed {
        pay_len_t len;
        csum_t csum;  // Complement of the folded payload sum
    } seg_summary_t;

    typedef enum logic [1:0] {
        gen_idle,
        gen_ip_hdr,
        gen_tcp_hdr,
        gen_payload
    } gen_state_e;

endpackage
